/* source/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // byte addressing, one 64-bit fetch block per Wishbone read
    localparam int AddrWidth = 32;
    localparam int BlockBytes = 8;
    localparam int OffsetWidth = $clog2(BlockBytes);
    localparam int BlockAddrWidth = AddrWidth - OffsetWidth;

    // 16-bit parcels inside a block
    localparam int SlotCount = 4;
    localparam int SlotWidth = $clog2(SlotCount);

    localparam int FetchIdWidth = 4;

    // direct mapped, index from block address bits 6:3
    localparam int BtbEntries = 16;
    localparam int BtbIndexWidth = $clog2(BtbEntries);
    localparam int BtbTagWidth = BlockAddrWidth - BtbIndexWidth;

    typedef logic [FetchIdWidth-1:0] fetchId_t;
    typedef logic [SlotWidth-1:0] slot_t;

    typedef struct packed {
        logic [BlockAddrWidth-1:0] blockPc;
        logic predTaken;
        slot_t predSlot;
        slot_t firstSlot;
    } pcEntry_t;

endpackage

`default_nettype wire

/* source/predictIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface predictIf;
    import fetchPkg::*;

    logic [AddrWidth-1:0] lookupPc;
    logic hit;
    logic taken;
    slot_t srcSlot;
    logic [AddrWidth-1:0] target;

    modport fetch (
        output lookupPc,
        input hit, taken, srcSlot, target
    );

    modport predictor (
        input lookupPc,
        output hit, taken, srcSlot, target
    );

endinterface

`default_nettype wire

/* source/branchTargetBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer (
    input logic clk,
    input logic rst,
    predictIf.predictor pred,
    input logic trainValid,
    input logic [fetchPkg::AddrWidth-1:0] trainPc,
    input logic [fetchPkg::AddrWidth-1:0] trainTarget,
    input logic trainTaken
);
    import fetchPkg::*;

    logic entryValid [BtbEntries];
    logic [BtbTagWidth-1:0] entryTag [BtbEntries];
    slot_t entrySlot [BtbEntries];
    logic [AddrWidth-1:0] entryTarget [BtbEntries];
    logic entryTaken [BtbEntries];

    logic [BtbIndexWidth-1:0] lookIdx;
    logic [BtbTagWidth-1:0] lookTag;
    slot_t lookSlot;

    logic [BtbIndexWidth-1:0] trainIdx;
    logic [BtbTagWidth-1:0] trainTag;
    slot_t trainSlot;

    assign lookIdx = pred.lookupPc[OffsetWidth +: BtbIndexWidth];
    assign lookTag = pred.lookupPc[AddrWidth-1 -: BtbTagWidth];
    assign lookSlot = pred.lookupPc[OffsetWidth-1:1];

    assign trainIdx = trainPc[OffsetWidth +: BtbIndexWidth];
    assign trainTag = trainPc[AddrWidth-1 -: BtbTagWidth];
    assign trainSlot = trainPc[OffsetWidth-1:1];

    // a branch before the starting slot was already passed in this block
    assign pred.hit = entryValid[lookIdx]
                   && (entryTag[lookIdx] == lookTag)
                   && (entrySlot[lookIdx] >= lookSlot);
    assign pred.taken = entryTaken[lookIdx];
    assign pred.srcSlot = entrySlot[lookIdx];
    assign pred.target = entryTarget[lookIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BtbEntries; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (trainValid) begin
            entryValid[trainIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (trainValid) begin
            entryTag[trainIdx] <= trainTag;
            entrySlot[trainIdx] <= trainSlot;
            entryTarget[trainIdx] <= trainTarget;
            entryTaken[trainIdx] <= trainTaken;
        end
    end

endmodule

`default_nettype wire

/* source/pcFile.sv */
`timescale 1ns/1ps
`default_nettype none

module pcFile (
    input logic clk,
    input logic writeEn,
    input fetchPkg::fetchId_t writeId,
    input fetchPkg::pcEntry_t writeData,
    input fetchPkg::fetchId_t readId,
    output fetchPkg::pcEntry_t readData
);
    import fetchPkg::*;

    // one entry per fetch ID in flight
    pcEntry_t entries [2**FetchIdWidth];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            entries[writeId] <= writeData;
        end
    end

    assign readData = entries[readId];

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input logic clk,
    input logic rst,
    input logic redirectValid,
    input logic [fetchPkg::AddrWidth-1:0] redirectPc,
    input fetchPkg::fetchId_t redirectId,
    input fetchPkg::fetchId_t commitId,

    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [fetchPkg::AddrWidth-1:0] wbAdr,
    input logic [fetchPkg::BlockBytes*8-1:0] wbDatIn,
    input logic wbAck,

    output logic instrValid,
    input logic ready,
    output logic [fetchPkg::BlockBytes*8-1:0] instrData,
    output logic [fetchPkg::AddrWidth-1:0] instrPc,
    output fetchPkg::fetchId_t fetchId,
    output fetchPkg::slot_t firstSlot,
    output fetchPkg::slot_t lastSlot,
    output logic predTaken,
    output logic [fetchPkg::AddrWidth-1:0] predTarget,

    predictIf.fetch pred,
    output logic pcWriteEn,
    output fetchPkg::fetchId_t pcWriteId,
    output fetchPkg::pcEntry_t pcWriteData
);
    import fetchPkg::*;

    logic busy;
    logic dropData;
    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] adrReg;
    fetchId_t idCounter;
    pcEntry_t outEntry;

    logic [AddrWidth-1:0] nextPc;
    slot_t branchSlot;
    logic startCycle;
    logic ackTaken;
    logic transfer;

    assign transfer = instrValid && ready;
    assign ackTaken = busy && wbAck && !dropData;

    // next cycle waits for a free output slot and a free fetch ID;
    // idCounter is the ID the next block will carry
    assign startCycle = !busy
                     && (!instrValid || ready)
                     && (idCounter != commitId)
                     && !redirectValid;

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe = 1'b0;
    assign wbAdr = adrReg;

    assign pred.lookupPc = pc;

    // slot right after a not-taken branch
    assign branchSlot = slot_t'(pred.srcSlot + 1'b1);

    always_comb begin
        if (pred.hit && pred.taken) begin
            nextPc = pred.target;
        end else if (pred.hit && pred.srcSlot < slot_t'(SlotCount - 1)) begin
            nextPc = {pc[AddrWidth-1:OffsetWidth], branchSlot, 1'b0};
        end else begin
            nextPc = {pc[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}} + BlockBytes;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            dropData <= 1'b0;
            pc <= '0;
            idCounter <= '0;
            instrValid <= 1'b0;
        end else begin
            if (transfer) begin
                instrValid <= 1'b0;
            end
            if (startCycle) begin
                busy <= 1'b1;
            end
            if (busy && wbAck) begin
                busy <= 1'b0;
                dropData <= 1'b0;
                if (!dropData && !redirectValid) begin
                    instrValid <= 1'b1;
                    pc <= nextPc;
                    idCounter <= fetchId_t'(idCounter + 1'b1);
                end
            end
            // redirect wins over everything else this cycle
            if (redirectValid) begin
                pc <= redirectPc;
                idCounter <= fetchId_t'(redirectId + 1'b1);
                instrValid <= 1'b0;
                dropData <= busy && !wbAck;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startCycle) begin
            adrReg <= {pc[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        end
        if (ackTaken) begin
            instrData <= wbDatIn;
            fetchId <= idCounter;
            predTarget <= nextPc;
            outEntry.blockPc <= pc[AddrWidth-1:OffsetWidth];
            outEntry.predTaken <= pred.hit && pred.taken;
            outEntry.predSlot <= pred.hit ? pred.srcSlot : slot_t'(SlotCount - 1);
            outEntry.firstSlot <= pc[OffsetWidth-1:1];
        end
    end

    assign instrPc = {outEntry.blockPc, {OffsetWidth{1'b0}}};
    assign firstSlot = outEntry.firstSlot;
    assign lastSlot = outEntry.predSlot;
    assign predTaken = outEntry.predTaken;

    // record the block once decode has it
    assign pcWriteEn = transfer;
    assign pcWriteId = fetchId;
    assign pcWriteData = outEntry;

endmodule

`default_nettype wire

/* source/fetchTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
    input logic clk,
    input logic rst,
    input logic redirectValid,
    input logic [fetchPkg::AddrWidth-1:0] redirectPc,
    input fetchPkg::fetchId_t redirectId,
    input fetchPkg::fetchId_t commitId,

    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [fetchPkg::AddrWidth-1:0] wbAdr,
    input logic [fetchPkg::BlockBytes*8-1:0] wbDatIn,
    input logic wbAck,

    output logic instrValid,
    input logic ready,
    output logic [fetchPkg::BlockBytes*8-1:0] instrData,
    output logic [fetchPkg::AddrWidth-1:0] instrPc,
    output fetchPkg::fetchId_t fetchId,
    output fetchPkg::slot_t firstSlot,
    output fetchPkg::slot_t lastSlot,
    output logic predTaken,
    output logic [fetchPkg::AddrWidth-1:0] predTarget,

    input logic trainValid,
    input logic [fetchPkg::AddrWidth-1:0] trainPc,
    input logic [fetchPkg::AddrWidth-1:0] trainTarget,
    input logic trainTaken,

    input fetchPkg::fetchId_t pcReadId,
    output fetchPkg::pcEntry_t pcReadData
);
    import fetchPkg::*;

    logic pcWriteEn;
    fetchId_t pcWriteId;
    pcEntry_t pcWriteData;

    predictIf predBus ();

    fetchUnit fetchUnit_i (
        .clk(clk),
        .rst(rst),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .redirectId(redirectId),
        .commitId(commitId),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck),
        .instrValid(instrValid),
        .ready(ready),
        .instrData(instrData),
        .instrPc(instrPc),
        .fetchId(fetchId),
        .firstSlot(firstSlot),
        .lastSlot(lastSlot),
        .predTaken(predTaken),
        .predTarget(predTarget),
        .pred(predBus),
        .pcWriteEn(pcWriteEn),
        .pcWriteId(pcWriteId),
        .pcWriteData(pcWriteData)
    );

    branchTargetBuffer btb_i (
        .clk(clk),
        .rst(rst),
        .pred(predBus),
        .trainValid(trainValid),
        .trainPc(trainPc),
        .trainTarget(trainTarget),
        .trainTaken(trainTaken)
    );

    pcFile pcFile_i (
        .clk(clk),
        .writeEn(pcWriteEn),
        .writeId(pcWriteId),
        .writeData(pcWriteData),
        .readId(pcReadId),
        .readData(pcReadData)
    );

endmodule

`default_nettype wire

/* test/fetchTop_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchProps (
    input logic clk,
    input logic rst,
    input logic wbCyc,
    input logic wbStb,
    input logic [31:0] wbAdr,
    input logic wbAck,
    input logic redirectValid,
    input logic instrValid,
    input logic ready,
    input logic [63:0] instrData,
    input logic [31:0] instrPc,
    input logic [3:0] fetchId,
    input logic [1:0] firstSlot,
    input logic [1:0] lastSlot,
    input logic predTaken,
    input logic [31:0] predTarget
);

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else $error("stb without cyc");

    // request stays put until the slave answers
    stbHolds: assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr))
        else $error("stb or adr changed before ack");

    // a redirect may withdraw the block
    outputHolds: assert property (@(posedge clk) disable iff (rst)
        instrValid && !ready && !redirectValid |=>
            instrValid && $stable(instrData) && $stable(instrPc) && $stable(fetchId)
            && $stable(firstSlot) && $stable(lastSlot) && $stable(predTaken)
            && $stable(predTarget))
        else $error("output changed while stalled");

    idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbCyc && !instrValid)
        else $error("bus or output active after reset");

endmodule

bind fetchUnit fetchProps props_i (
    .clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbAck(wbAck),
    .redirectValid(redirectValid), .instrValid(instrValid), .ready(ready),
    .instrData(instrData), .instrPc(instrPc), .fetchId(fetchId),
    .firstSlot(firstSlot), .lastSlot(lastSlot), .predTaken(predTaken),
    .predTarget(predTarget)
);

`default_nettype wire

/* test/fetchTop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchTop_tb;
    import fetchPkg::*;

    logic clk = 1'b0;
    logic rst, redirectValid, wbCyc, wbStb, wbWe, wbAck, instrValid, ready, predTaken;
    logic trainValid, trainTaken, armed;
    logic [31:0] redirectPc, wbAdr, instrPc, predTarget, trainPc, trainTarget, refPc;
    logic [63:0] wbDatIn, instrData;
    fetchId_t redirectId, commitId, fetchId, pcReadId, refId;
    slot_t firstSlot, lastSlot;
    pcEntry_t pcReadData;
    logic mValid [16];
    logic [31:0] mPc [16];
    logic [31:0] mTarget [16];
    logic mTaken [16];
    int waitLeft, maxHold, errorCount, timeoutCount, fd, a, b, c, d, e;
    logic aborted;
    string line, cmd;

    fetchTop fetchTop_i (.*);

    always #5 clk = ~clk;

    // each slot holds its own halfword address
    function automatic logic [63:0] memWord(input logic [31:0] adr);
        logic [15:0] half;
        half = adr[16:1];
        return {half + 16'd3, half + 16'd2, half + 16'd1, half};
    endfunction

    // slave with a random number of wait states
    always @(posedge clk) begin
        if (rst || wbAck) begin
            wbAck <= 1'b0;
            armed <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!armed) begin
                armed <= 1'b1;
                waitLeft <= $urandom % 4;
            end else if (waitLeft == 0) begin
                if (wbWe !== 1'b0) begin
                    $display("ERR %0t: write enable set during a fetch read", $time);
                    errorCount++;
                end
                wbAck <= 1'b1;
                wbDatIn <= memWord(wbAdr);
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    task automatic takeBlock(input logic [31:0] block, input int first, last, taken);
        int idx;
        int n;
        logic hit;
        logic mT;
        int mLast;
        logic [31:0] nextPc;
        idx = refPc[6:3];
        hit = mValid[idx] && mPc[idx][31:7] == refPc[31:7] && mPc[idx][2:1] >= refPc[2:1];
        mT = hit && mTaken[idx];
        mLast = hit ? mPc[idx][2:1] : 3;
        if (mT)
            nextPc = mTarget[idx];
        else if (hit && mLast < 3)
            nextPc = {refPc[31:3], 3'b0} + 2 * (mLast + 1);
        else
            nextPc = {refPc[31:3], 3'b0} + 8;
        if ({refPc[31:3], 3'b0} != block || refPc[2:1] != first || mLast != last
                || mT != taken) begin
            $display("ERR %0t: model expects %h/%0d/%0d/%0d", $time, refPc, refPc[2:1],
                     mLast, mT);
            errorCount++;
        end
        n = 0;
        @(negedge clk);
        while (!instrValid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!instrValid) begin
            $display("timeout waiting for the block at %h", block);
            timeoutCount++;
            aborted = 1'b1;
            return;
        end
        repeat (maxHold > 0 ? $urandom % (maxHold + 1) : 0) @(negedge clk);
        @(posedge clk) ready <= 1'b1;
        @(negedge clk);
        if (!instrValid || instrPc !== block || firstSlot !== first || lastSlot !== last
                || predTaken !== taken || fetchId !== refId || predTarget !== nextPc) begin
            $display("ERR %0t: block %h id %0d slots %0d-%0d taken %0d target %h", $time,
                     instrPc, fetchId, firstSlot, lastSlot, predTaken, predTarget);
            errorCount++;
        end
        if (instrData !== memWord(block)) begin
            $display("ERR %0t: data %h at %h", $time, instrData, block);
            errorCount++;
        end
        @(posedge clk) ready <= 1'b0;
        refPc = nextPc;
        refId = fetchId_t'(refId + 1);
    endtask

    initial begin
        void'($urandom(32'h8000e39e));
        {rst, redirectValid, redirectPc, redirectId, commitId, wbAck, wbDatIn} = '0;
        {ready, trainValid, trainPc, trainTarget, trainTaken, pcReadId, armed} = '0;
        rst = 1'b1;
        {refPc, refId, maxHold, errorCount, timeoutCount, aborted} = '0;
        for (int i = 0; i < 16; i++) begin
            mValid[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("test/fetchStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd) && $fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            void'($sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, e));
            case (cmd)
                "T": begin
                    @(posedge clk);
                    {trainValid, trainPc, trainTarget, trainTaken} <= {1'b1, a, b, c[0]};
                    @(posedge clk) trainValid <= 1'b0;
                    mValid[a[6:3]] = 1'b1;
                    mPc[a[6:3]] = a;
                    mTarget[a[6:3]] = b;
                    mTaken[a[6:3]] = c[0];
                end
                "R": begin
                    @(posedge clk);
                    {redirectValid, redirectPc, redirectId} <= {1'b1, a, b[3:0]};
                    @(posedge clk) redirectValid <= 1'b0;
                    refPc = a;
                    refId = fetchId_t'(b + 1);
                end
                "C": @(posedge clk) commitId <= a[3:0];
                "H": maxHold = a;
                "E": takeBlock(a, b, c, d);
                "S": repeat (a) begin
                    @(negedge clk);
                    if (instrValid) begin
                        $display("ERR %0t: block appeared with the ID window full", $time);
                        errorCount++;
                    end
                end
                "P": begin
                    @(posedge clk) pcReadId <= a[3:0];
                    @(negedge clk);
                    if ({pcReadData.blockPc, 3'b0} !== b || pcReadData.firstSlot !== c
                            || pcReadData.predSlot !== d || pcReadData.predTaken !== e[0]) begin
                        $display("ERR %0t: PC file id %0d holds %h", $time, a, pcReadData);
                        errorCount++;
                    end
                end
                default: begin
                    $display("unknown stimulus command %s", cmd);
                    errorCount++;
                end
            endcase
        end
        $display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0 && !aborted) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetchTop.f */
source/fetchPkg.sv
source/predictIf.sv
source/branchTargetBuffer.sv
source/pcFile.sv
source/fetchUnit.sv
source/fetchTop.sv
test/fetchTop_props.sv
test/fetchTop_tb.sv

/* test/fetchStimulus.txt */
# T pc target taken | R pc id | C commitId | H maxHold | S cycles
# E block first last taken | P id block first last taken
C f
E 0 0 3 0
E 8 0 3 0
E 10 0 3 0
T 104 126 1
T 1c2 0 0
R 100 5
E 100 0 2 1
E 120 3 3 0
E 128 0 3 0
R 1c0 9
E 1c0 0 1 0
E 1c0 2 3 0
E 1c8 0 3 0
C 8
H 3
E 1d0 0 3 0
E 1d8 0 3 0
E 1e0 0 3 0
E 1e8 0 3 0
H 0
C 2
E 1f0 0 3 0
S 20
P 1 1f0 0 3 0
P 6 100 0 2 1
C 8
E 1f8 0 3 0
